//--- verilog/cdd_pkg.sv
// CD drive controller shared definitions
// Bus frame geometry, command, TOC and status codes, fixed disc TOC
`default_nettype none

package cdd_pkg;

	// ==============================
	// Frame geometry
	// ==============================

	// Nibbles per frame, both directions
	localparam int unsigned FRAME_NIBBLES = 10;
	localparam int unsigned FRAME_BITS = 40;

	// ==============================
	// Host command codes
	// ==============================

	localparam logic [3:0] CMD_NOP = 4'd0;
	localparam logic [3:0] CMD_STOP = 4'd1;
	localparam logic [3:0] CMD_TOC = 4'd2;
	localparam logic [3:0] CMD_PLAY = 4'd3;
	// Known to the drive but answered as NOP
	localparam logic [3:0] CMD_SEEK = 4'd4;
	localparam logic [3:0] CMD_PAUSE = 4'd6;
	localparam logic [3:0] CMD_RESUME = 4'd7;
	localparam logic [3:0] CMD_FFW = 4'd8;
	localparam logic [3:0] CMD_REW = 4'd9;
	localparam logic [3:0] CMD_CLOSE = 4'd12;
	localparam logic [3:0] CMD_OPEN = 4'd13;

	// TOC sub-commands, others read back as zeros
	localparam logic [3:0] TOC_LENGTH = 4'd3;
	localparam logic [3:0] TOC_FIRSTLAST = 4'd4;
	localparam logic [3:0] TOC_START = 4'd5;

	// Drive status codes
	localparam logic [3:0] STAT_STOPPED = 4'd0;
	localparam logic [3:0] STAT_PLAYING = 4'd1;
	localparam logic [3:0] STAT_PAUSED = 4'd4;
	localparam logic [3:0] STAT_READTOC = 4'd9;

	// ==============================
	// Disc table of contents
	// ==============================

	// Track numbers in BCD
	localparam logic [7:0] TOC_FIRST_TRACK = 8'h01;
	localparam logic [7:0] TOC_LAST_TRACK = 8'h03;

	// Lead-out, i.e. disc length 20:15:33
	localparam logic [7:0] TOC_LEADOUT_M = 8'h20;
	localparam logic [7:0] TOC_LEADOUT_S = 8'h15;
	localparam logic [7:0] TOC_LEADOUT_F = 8'h33;

	// Track starts, index 0 is track 1
	localparam logic [2:0][7:0] TOC_START_M = {8'h12, 8'h05, 8'h00};
	localparam logic [2:0][7:0] TOC_START_S = {8'h03, 8'h40, 8'h02};
	localparam logic [2:0][7:0] TOC_START_F = {8'h70, 8'h12, 8'h00};
	// Track type nibble, 4 data and 0 audio
	localparam logic [2:0][3:0] TOC_TYPE = {4'h0, 4'h0, 4'h4};

endpackage

`default_nettype wire

//--- verilog/cdd_msf_counter.sv
// Absolute position counter in BCD minutes, seconds, frames
// Loadable, steps one frame per interrupt period while running
`timescale 1ns/1ps
`default_nettype none

module cdd_msf_counter (
	input wire clk_sys,
	input wire nRESET,
	input wire irq_pulse,
	input wire msf_run,
	input wire msf_load,
	input wire [23:0] msf_load_value,
	output logic [23:0] msf
);

	// One BCD digit pair plus one, wraps to zero after last
	function automatic logic [7:0] bcd_step(input logic [7:0] v, input logic [7:0] last);
		logic [7:0] nxt;
		if (v == last)
			nxt = 8'h00;
		else if (v[3:0] == 4'd9)
			nxt = {v[7:4] + 4'd1, 4'd0};
		else
			nxt = v + 8'd1;
		return nxt;
	endfunction

	logic [7:0] min_q;
	logic [7:0] sec_q;
	logic [7:0] frm_q;
	logic frm_wrap;
	logic sec_wrap;

	assign msf = {min_q, sec_q, frm_q};
	// 75 frames per second, 60 seconds per minute
	assign frm_wrap = (frm_q == 8'h74);
	assign sec_wrap = (sec_q == 8'h59);

	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			min_q <= 8'h00;
			sec_q <= 8'h00;
			frm_q <= 8'h00;
		end
		else if (msf_load)
		begin
			min_q <= msf_load_value[23:16];
			sec_q <= msf_load_value[15:8];
			frm_q <= msf_load_value[7:0];
		end
		else if (irq_pulse & msf_run)
		begin
			frm_q <= bcd_step(frm_q, 8'h74);
			if (frm_wrap)
			begin
				sec_q <= bcd_step(sec_q, 8'h59);
				// Minutes roll over past 99
				if (sec_wrap)
					min_q <= bcd_step(min_q, 8'h99);
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/cdd_toc.sv
// Fixed disc TOC lookup
// Answers length, first/last and track start sub-commands
`timescale 1ns/1ps
`default_nettype none

module cdd_toc (
	input wire [3:0] toc_sub,
	input wire [7:0] toc_track,
	output logic [23:0] toc_data,
	output logic [3:0] toc_aux
);
	import cdd_pkg::*;

	logic [1:0] idx;
	logic track_ok;

	// BCD track 01..03 maps to table index 0..2
	assign idx = toc_track[1:0] - 2'd1;
	assign track_ok = (toc_track >= TOC_FIRST_TRACK) && (toc_track <= TOC_LAST_TRACK);

	always_comb
	begin
		toc_data = '0;
		toc_aux = '0;
		case (toc_sub)
			TOC_LENGTH:
				toc_data = {TOC_LEADOUT_M, TOC_LEADOUT_S, TOC_LEADOUT_F};
			TOC_FIRSTLAST:
				toc_data = {TOC_FIRST_TRACK, TOC_LAST_TRACK, 8'h00};
			TOC_START:
			begin
				// Out of range track reads as zeros
				if (track_ok)
				begin
					toc_data = {TOC_START_M[idx], TOC_START_S[idx], TOC_START_F[idx]};
					toc_aux = TOC_TYPE[idx];
				end
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/cdd_link.sv
// CDD host bus engine
// Emulates the slow drive MCU: interrupt timer, status nibble send,
// command nibble receive over the 4-bit HOCK/CDCK handshake
`timescale 1ns/1ps
`default_nettype none

module cdd_link #(
	parameter int TICK_DIV = 192,
	parameter int IRQ_PERIOD = 3906
) (
	input wire clk_sys,
	input wire nRESET,
	input wire hock,
	output logic cdck,
	input wire [3:0] cdd_din,
	output logic [3:0] cdd_dout,
	output logic cdd_nirq,
	input wire [cdd_pkg::FRAME_BITS-1:0] status_in,
	input wire status_latch,
	output logic [cdd_pkg::FRAME_BITS-1:0] command_data,
	output logic command_send,
	output logic irq_pulse
);
	import cdd_pkg::*;

	localparam int DIV_W = $clog2(TICK_DIV + 1);
	localparam int IRQ_W = $clog2(IRQ_PERIOD + 1);
	localparam logic [3:0] ALL_NIB = 4'(FRAME_NIBBLES);
	localparam logic [3:0] LAST_NIB = 4'(FRAME_NIBBLES - 1);

	// Bus sequencer states
	localparam logic [1:0] S_SETUP = 2'd0;
	localparam logic [1:0] S_WAIT_HI = 2'd1;
	localparam logic [1:0] S_WAIT_LO = 2'd2;

	logic [DIV_W-1:0] div_cnt;
	logic [IRQ_W-1:0] irq_timer;
	logic tick;
	// 0..10, 10 means phase done
	logic [3:0] dout_cnt;
	logic [3:0] din_cnt;
	logic [FRAME_BITS-1:0] status_buf;
	logic latch_d;
	logic status_pending;
	logic hock_prev;
	logic hock_rise;
	logic hock_fall;
	logic [1:0] bus_state;
	logic comm_run;
	logic sending;

	assign tick = (div_cnt == DIV_W'(TICK_DIV - 1));
	assign hock_rise = ~hock_prev & hock;
	assign hock_fall = hock_prev & ~hock;
	// Status nibbles still going out
	assign sending = comm_run & (dout_cnt != ALL_NIB);

	// ==============================
	// MCU tick divider
	// ==============================

	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
			div_cnt <= '0;
		else if (tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// ==============================
	// Bus engine
	// ==============================

	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			irq_timer <= '0;
			dout_cnt <= '0;
			din_cnt <= '0;
			hock_prev <= 1'b1;
			cdck <= 1'b1;
			cdd_nirq <= 1'b1;
			bus_state <= S_SETUP;
			comm_run <= 1'b0;
			// STOPPED, all zeros, checksum included
			status_buf <= {~STAT_STOPPED, 32'h0, STAT_STOPPED};
			status_pending <= 1'b0;
			latch_d <= 1'b0;
			command_send <= 1'b0;
			irq_pulse <= 1'b0;
		end
		else
		begin
			latch_d <= status_latch;
			command_send <= 1'b0;
			irq_pulse <= 1'b0;

			// Remember a new status until the buffer is free
			if (~latch_d & status_latch)
				status_pending <= 1'b1;

			if (tick)
			begin
				hock_prev <= hock;

				if (status_pending & ~sending)
				begin
					status_pending <= 1'b0;
					status_buf <= status_in;
				end

				if (comm_run)
				begin
					if (dout_cnt != ALL_NIB)
					begin
						// Drive to host
						case (bus_state)
							S_SETUP:
							begin
								cdd_dout <= status_buf[{dout_cnt, 2'b00} +: 4];
								cdck <= 1'b0;
								bus_state <= S_WAIT_HI;
							end
							S_WAIT_HI:
							begin
								if (hock_rise)
								begin
									cdck <= 1'b1;
									bus_state <= S_WAIT_LO;
									// Last nibble hands over to receive
									if (dout_cnt == LAST_NIB)
										dout_cnt <= ALL_NIB;
								end
							end
							default:
							begin
								if (hock_fall)
								begin
									dout_cnt <= dout_cnt + 1'b1;
									bus_state <= S_SETUP;
								end
							end
						endcase
					end
					else if (din_cnt != ALL_NIB)
					begin
						// Host to drive
						if (bus_state == S_WAIT_HI)
						begin
							if (hock_rise)
							begin
								command_data[{din_cnt, 2'b00} +: 4] <= cdd_din;
								cdck <= 1'b1;
								din_cnt <= din_cnt + 1'b1;
								bus_state <= S_WAIT_LO;
							end
						end
						else if (hock_fall)
						begin
							cdck <= 1'b0;
							bus_state <= S_WAIT_HI;
						end
					end
					else
					begin
						// Frame complete, CDCK left high
						command_send <= 1'b1;
						comm_run <= 1'b0;
					end
				end

				// Host answered the interrupt
				if (~hock & ~cdd_nirq)
				begin
					cdd_nirq <= 1'b1;
					comm_run <= 1'b1;
					dout_cnt <= '0;
					din_cnt <= '0;
					bus_state <= S_SETUP;
				end

				// Period start wins over everything above
				if (irq_timer == IRQ_W'(IRQ_PERIOD - 1))
				begin
					irq_timer <= '0;
					cdd_nirq <= 1'b0;
					irq_pulse <= 1'b1;
					comm_run <= 1'b0;
					cdck <= 1'b1;
					bus_state <= S_SETUP;
				end
				else
				begin
					// Unanswered interrupt gives up at half period
					if (irq_timer == IRQ_W'(IRQ_PERIOD / 2 - 1))
						cdd_nirq <= 1'b1;
					irq_timer <= irq_timer + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/cdd_controller.sv
// CDD command controller
// Checks and decodes host commands, keeps the drive state and
// builds each status frame with its checksum
`timescale 1ns/1ps
`default_nettype none

module cdd_controller (
	input wire clk_sys,
	input wire nRESET,
	input wire [cdd_pkg::FRAME_BITS-1:0] command_data,
	input wire command_send,
	input wire irq_pulse,
	output logic [cdd_pkg::FRAME_BITS-1:0] status_in,
	output logic status_latch,
	input wire [23:0] msf,
	output logic msf_load,
	output logic [23:0] msf_load_value,
	output logic msf_run,
	output logic [3:0] toc_sub,
	output logic [7:0] toc_track,
	input wire [23:0] toc_data,
	input wire [3:0] toc_aux,
	output logic [3:0] drive_status
);
	import cdd_pkg::*;

	// Inverted 4-bit sum of nibbles 0..8
	function automatic logic [3:0] frame_check(input logic [FRAME_BITS-5:0] body);
		logic [3:0] sum;
		sum = '0;
		for (int i = 0; i < FRAME_NIBBLES - 1; i++)
			sum = sum + body[4*i +: 4];
		return ~sum;
	endfunction

	logic [3:0] cmd_code;
	logic [3:0] cmd_sub;
	logic [23:0] cmd_msf;
	logic [7:0] cmd_track;
	logic cmd_ok;
	logic accept;
	logic rebuild;
	logic [23:0] pos;
	logic [23:0] data;
	logic [3:0] cur_track;
	logic [3:0] nib8;
	logic [FRAME_BITS-5:0] body;

	// ==============================
	// Command fields
	// ==============================

	assign cmd_code = command_data[3:0];
	assign cmd_sub = command_data[7:4];
	// BCD bytes arrive high nibble first
	assign cmd_msf = {command_data[11:8], command_data[15:12], command_data[19:16],
		command_data[23:20], command_data[27:24], command_data[31:28]};
	assign cmd_track = cmd_msf[23:16];
	assign cmd_ok = (command_data[39:36] == frame_check(command_data[35:0]));
	assign accept = command_send & cmd_ok;

	// ==============================
	// Status frame
	// ==============================

	// A load in flight is reported already
	assign pos = msf_load ? msf_load_value : msf;
	assign data = (drive_status == STAT_READTOC) ? toc_data : pos;

	// Track under the head, BCD compare works as binary
	always_comb
	begin
		if (pos >= {TOC_START_M[2], TOC_START_S[2], TOC_START_F[2]})
			cur_track = 4'd3;
		else if (pos >= {TOC_START_M[1], TOC_START_S[1], TOC_START_F[1]})
			cur_track = 4'd2;
		else
			cur_track = 4'd1;
	end

	// Nibble 8 carries the track type while reading TOC
	assign nib8 = (drive_status == STAT_READTOC) ? toc_aux :
		(drive_status == STAT_STOPPED) ? 4'd0 : cur_track;

	// Sub-code echo only meaningful in READTOC
	assign body = {nib8, data[3:0], data[7:4], data[11:8], data[15:12], data[19:16],
		data[23:20], (drive_status == STAT_READTOC) ? toc_sub : 4'd0, drive_status};

	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			drive_status <= STAT_STOPPED;
			msf_run <= 1'b0;
			msf_load <= 1'b0;
			toc_sub <= '0;
			toc_track <= '0;
			rebuild <= 1'b0;
			status_latch <= 1'b0;
			status_in <= {~STAT_STOPPED, 32'h0, STAT_STOPPED};
		end
		else
		begin
			msf_load <= 1'b0;
			status_latch <= 1'b0;
			// Stage 1 decides, stage 2 publishes
			rebuild <= accept | irq_pulse;

			if (accept)
			begin
				case (cmd_code)
					CMD_STOP:
					begin
						drive_status <= STAT_STOPPED;
						msf_run <= 1'b0;
						msf_load <= 1'b1;
						msf_load_value <= '0;
					end
					CMD_PLAY:
					begin
						drive_status <= STAT_PLAYING;
						msf_run <= 1'b1;
						msf_load <= 1'b1;
						msf_load_value <= cmd_msf;
					end
					CMD_TOC:
					begin
						drive_status <= STAT_READTOC;
						msf_run <= 1'b0;
						toc_sub <= cmd_sub;
						toc_track <= cmd_track;
					end
					CMD_PAUSE:
					begin
						drive_status <= STAT_PAUSED;
						msf_run <= 1'b0;
					end
					CMD_RESUME:
					begin
						if (drive_status == STAT_PAUSED)
						begin
							drive_status <= STAT_PLAYING;
							msf_run <= 1'b1;
						end
					end
					CMD_NOP, CMD_SEEK, CMD_FFW, CMD_REW, CMD_CLOSE, CMD_OPEN: ;
					default: ;
				endcase
			end

			if (rebuild)
			begin
				status_in <= {frame_check(body), body};
				status_latch <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/cdd_top.sv
// CD drive controller top level
// Host bus link, command controller, position counter and TOC table
`timescale 1ns/1ps
`default_nettype none

module cdd_top #(
	parameter int TICK_DIV = 192,
	parameter int IRQ_PERIOD = 3906
) (
	input wire clk_sys,
	input wire nRESET,
	input wire hock,
	output logic cdck,
	input wire [3:0] cdd_din,
	output logic [3:0] cdd_dout,
	output logic cdd_nirq,
	output logic [3:0] drive_status,
	output logic [23:0] cur_msf
);
	import cdd_pkg::*;

	logic [FRAME_BITS-1:0] command_data;
	logic command_send;
	logic [FRAME_BITS-1:0] status_in;
	logic status_latch;
	logic irq_pulse;
	logic msf_load;
	logic [23:0] msf_load_value;
	logic msf_run;
	logic [3:0] toc_sub;
	logic [7:0] toc_track;
	logic [23:0] toc_data;
	logic [3:0] toc_aux;

	// Host bus side
	cdd_link #(
		.TICK_DIV(TICK_DIV),
		.IRQ_PERIOD(IRQ_PERIOD)
	) u_link (
		.clk_sys(clk_sys),
		.nRESET(nRESET),
		.hock(hock),
		.cdck(cdck),
		.cdd_din(cdd_din),
		.cdd_dout(cdd_dout),
		.cdd_nirq(cdd_nirq),
		.status_in(status_in),
		.status_latch(status_latch),
		.command_data(command_data),
		.command_send(command_send),
		.irq_pulse(irq_pulse)
	);

	// Drive state and status builder
	cdd_controller u_ctrl (
		.clk_sys(clk_sys),
		.nRESET(nRESET),
		.command_data(command_data),
		.command_send(command_send),
		.irq_pulse(irq_pulse),
		.status_in(status_in),
		.status_latch(status_latch),
		.msf(cur_msf),
		.msf_load(msf_load),
		.msf_load_value(msf_load_value),
		.msf_run(msf_run),
		.toc_sub(toc_sub),
		.toc_track(toc_track),
		.toc_data(toc_data),
		.toc_aux(toc_aux),
		.drive_status(drive_status)
	);

	cdd_msf_counter u_msf (
		.clk_sys(clk_sys),
		.nRESET(nRESET),
		.irq_pulse(irq_pulse),
		.msf_run(msf_run),
		.msf_load(msf_load),
		.msf_load_value(msf_load_value),
		.msf(cur_msf)
	);

	cdd_toc u_toc (
		.toc_sub(toc_sub),
		.toc_track(toc_track),
		.toc_data(toc_data),
		.toc_aux(toc_aux)
	);

endmodule

`default_nettype wire

//--- sim/cdd_host_model.svh
// CDD host bus model
// Host side of the HOCK/CDCK handshake: interrupt answer,
// status frame read and command frame write
`ifndef CDD_HOST_MODEL_SVH
`define CDD_HOST_MODEL_SVH

// Wait until cdck reaches a level, a couple of MCU ticks at most
task automatic wait_cdck(input logic level);
	int count;
	count = 0;
	while ((cdck !== level) && (count < STEP_TIMEOUT))
	begin
		@(negedge clk_sys);
		count++;
	end
	if (cdck !== level)
	begin
		timeouts++;
		timed_out = 1'b1;
		$display("Timeout: cdck did not go to %0b within %0d clocks", level, STEP_TIMEOUT);
	end
endtask

// Wait until cdd_nirq reaches a level within a given number of clocks
task automatic wait_nirq(input logic level, input int limit, input string what);
	int count;
	count = 0;
	while ((cdd_nirq !== level) && (count < limit))
	begin
		@(negedge clk_sys);
		count++;
	end
	if (cdd_nirq !== level)
	begin
		timeouts++;
		timed_out = 1'b1;
		$display("Timeout: %s within %0d clocks", what, limit);
	end
endtask

// Answer the next interrupt and read ten status nibbles
task automatic read_status(output logic [39:0] frame);
	int n;
	frame = '0;
	wait_nirq(1'b0, IRQ_TIMEOUT, "no interrupt arrived");
	if (timed_out)
		return;
	// Answer
	hock = 1'b0;
	for (n = 0; n < FRAME_NIBBLES; n++)
	begin
		// Nibble valid while cdck is low
		wait_cdck(1'b0);
		if (timed_out)
			return;
		frame[4*n +: 4] = cdd_dout;
		hock = 1'b1;
		wait_cdck(1'b1);
		if (timed_out)
			return;
		hock = 1'b0;
	end
endtask

// Send ten command nibbles right after the status phase
task automatic write_command(input logic [39:0] frame);
	int n;
	for (n = 0; n < FRAME_NIBBLES; n++)
	begin
		wait_cdck(1'b0);
		if (timed_out)
			return;
		cdd_din = frame[4*n +: 4];
		hock = 1'b1;
		wait_cdck(1'b1);
		if (timed_out)
			return;
		// Idle level after the last nibble is high
		if (n != FRAME_NIBBLES - 1)
			hock = 1'b0;
	end
endtask

// Let one interrupt pass without answering it
task automatic skip_irq();
	wait_nirq(1'b0, IRQ_TIMEOUT, "no interrupt arrived");
	if (timed_out)
		return;
	// Must release well before the next period
	wait_nirq(1'b1, IRQ_PERIOD * TICK_DIV * 3 / 4,
		"cdd_nirq stayed low after an unanswered interrupt");
endtask

`endif

//--- sim/tb_cdd.sv
// CD drive controller testbench
// Random command stream over the host bus, checked against a drive model
`timescale 1ns/1ps
`default_nettype none

module tb_cdd;
	import cdd_pkg::*;

	localparam int TICK_DIV = 4;
	localparam int IRQ_PERIOD = 400;
	localparam int NUM_FRAMES = 80;
	// Clocks per handshake step and per interrupt wait
	localparam int STEP_TIMEOUT = 8 * TICK_DIV;
	localparam int IRQ_TIMEOUT = 2 * IRQ_PERIOD * TICK_DIV;

	logic clk_sys;
	logic nRESET;
	logic hock;
	logic [3:0] cdd_din;
	wire cdck;
	wire [3:0] cdd_dout;
	wire cdd_nirq;
	wire [3:0] drive_status;
	wire [23:0] cur_msf;

	int checks;
	int errors;
	int timeouts;
	bit timed_out;

	// Drive model
	logic [3:0] exp_status;
	logic [3:0] exp_sub;
	logic [7:0] exp_track;
	logic [23:0] start_pos;
	logic [23:0] last_pos;
	// Model position and whether it steps each period
	logic [23:0] exp_pos;
	bit exp_run;

	`include "cdd_host_model.svh"

	cdd_top #(
		.TICK_DIV(TICK_DIV),
		.IRQ_PERIOD(IRQ_PERIOD)
	) UUT (
		.clk_sys(clk_sys),
		.nRESET(nRESET),
		.hock(hock),
		.cdck(cdck),
		.cdd_din(cdd_din),
		.cdd_dout(cdd_dout),
		.cdd_nirq(cdd_nirq),
		.drive_status(drive_status),
		.cur_msf(cur_msf)
	);

	// 100 ns clock
	initial
	begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ==============================
	// Check helpers
	// ==============================

	task automatic expect_equal(input string name, input logic [39:0] got,
		input logic [39:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic expect_true(input bit cond, input string what);
		checks++;
		assert (cond)
		else
		begin
			errors++;
			$display("Check failed: %s", what);
		end
	endtask

	// Inverted 4-bit sum of nibbles 0 to 8
	function automatic logic [3:0] checksum_of(input logic [35:0] body);
		logic [3:0] sum;
		int k;
		sum = 4'h0;
		for (k = 0; k < 9; k++)
			sum = sum + body[4*k +: 4];
		return ~sum;
	endfunction

	function automatic logic [7:0] to_bcd(input int v);
		return {4'(v / 10), 4'(v % 10)};
	endfunction

	// Frames below 75, seconds below 60, all digits decimal
	function automatic bit valid_bcd_pos(input logic [23:0] pos);
		bit ok;
		int k;
		ok = (pos[15:8] < 8'h60) && (pos[7:0] < 8'h75);
		for (k = 0; k < 6; k++)
			if (pos[4*k +: 4] > 4'd9)
				ok = 1'b0;
		return ok;
	endfunction

	// Payload bytes go out high nibble first
	function automatic logic [39:0] make_command(input logic [3:0] code,
		input logic [3:0] sub, input logic [23:0] payload);
		logic [35:0] body;
		body = {4'h0, payload[3:0], payload[7:4], payload[11:8], payload[15:12],
			payload[19:16], payload[23:20], sub, code};
		return {checksum_of(body), body};
	endfunction

	function automatic logic [23:0] frame_payload(input logic [39:0] frame);
		return {frame[11:8], frame[15:12], frame[19:16], frame[23:20], frame[27:24],
			frame[31:28]};
	endfunction

	// ==============================
	// Reference model
	// ==============================

	// One CD frame later, via plain integers
	function automatic logic [23:0] next_frame(input logic [23:0] pos);
		int m;
		int s;
		int f;
		m = 10 * pos[23:20] + pos[19:16];
		s = 10 * pos[15:12] + pos[11:8];
		f = 10 * pos[7:4] + pos[3:0];
		f++;
		if (f == 75)
		begin
			f = 0;
			s++;
		end
		if (s == 60)
		begin
			s = 0;
			m++;
		end
		if (m == 100)
			m = 0;
		return {to_bcd(m), to_bcd(s), to_bcd(f)};
	endfunction

	// Last track whose start is not after the position
	function automatic logic [3:0] track_at(input logic [23:0] pos);
		logic [3:0] trk;
		int k;
		trk = 4'd1;
		for (k = 1; k < 3; k++)
			if (pos >= {TOC_START_M[k], TOC_START_S[k], TOC_START_F[k]})
				trk = 4'(k + 1);
		return trk;
	endfunction

	// One interrupt period went by
	task automatic advance_model();
		if (exp_run)
			exp_pos = next_frame(exp_pos);
	endtask

	// Expected TOC answer from the disc table
	task automatic toc_expect(input logic [3:0] sub, input logic [7:0] track,
		output logic [23:0] data, output logic [3:0] aux);
		data = 24'h0;
		aux = 4'h0;
		if (sub == TOC_LENGTH)
			data = {TOC_LEADOUT_M, TOC_LEADOUT_S, TOC_LEADOUT_F};
		else if (sub == TOC_FIRSTLAST)
			data = {TOC_FIRST_TRACK, TOC_LAST_TRACK, 8'h00};
		else if ((sub == TOC_START) && (track >= 8'h01) && (track <= 8'h03))
		begin
			data = {TOC_START_M[track - 1], TOC_START_S[track - 1], TOC_START_F[track - 1]};
			aux = TOC_TYPE[track - 1];
		end
	endtask

	task automatic apply_command(input logic [39:0] cmd);
		logic [23:0] payload;
		payload = frame_payload(cmd);
		case (cmd[3:0])
			CMD_STOP:
			begin
				exp_status = STAT_STOPPED;
				start_pos = 24'h0;
				last_pos = 24'h0;
				exp_pos = 24'h0;
				exp_run = 1'b0;
			end
			CMD_PLAY:
			begin
				exp_status = STAT_PLAYING;
				start_pos = payload;
				last_pos = payload;
				exp_pos = payload;
				exp_run = 1'b1;
			end
			CMD_TOC:
			begin
				exp_status = STAT_READTOC;
				exp_sub = cmd[7:4];
				exp_track = payload[23:16];
				exp_run = 1'b0;
			end
			CMD_PAUSE:
			begin
				exp_status = STAT_PAUSED;
				exp_run = 1'b0;
			end
			CMD_RESUME:
				if (exp_status == STAT_PAUSED)
				begin
					exp_status = STAT_PLAYING;
					exp_run = 1'b1;
				end
			default: ;
		endcase
	endtask

	task automatic check_frame(input logic [39:0] frame, input bit first);
		logic [23:0] pos;
		logic [23:0] toc_data;
		logic [3:0] toc_aux;
		logic [3:0] exp_echo;
		pos = frame_payload(frame);
		expect_equal("cdd_dout checksum nibble", frame[39:36], checksum_of(frame[35:0]));
		expect_equal("cdd_dout status code", frame[3:0], exp_status);
		expect_equal("drive_status", drive_status, exp_status);
		// Counter output against the model position
		expect_equal("cur_msf", cur_msf, exp_pos);
		exp_echo = (exp_status == STAT_READTOC) ? exp_sub : 4'h0;
		expect_equal("cdd_dout sub-code echo", frame[7:4], exp_echo);
		if (first)
			expect_equal("first status nibbles 1-8", frame[35:4], 32'h0);
		case (exp_status)
			STAT_READTOC:
			begin
				toc_expect(exp_sub, exp_track, toc_data, toc_aux);
				expect_equal("cdd_dout TOC data", pos, toc_data);
				expect_equal("cdd_dout TOC type nibble", frame[35:32], toc_aux);
			end
			STAT_PLAYING:
			begin
				expect_true(valid_bcd_pos(pos),
					$sformatf("position 0x%06h is not a valid BCD time", pos));
				expect_true(pos >= start_pos,
					$sformatf("position 0x%06h is before start 0x%06h", pos, start_pos));
				expect_true(pos >= last_pos,
					$sformatf("position 0x%06h went back from 0x%06h", pos, last_pos));
				expect_equal("cdd_dout play position", pos, exp_pos);
				expect_equal("cdd_dout track nibble", frame[35:32], track_at(exp_pos));
				last_pos = pos;
			end
			STAT_PAUSED:
			begin
				expect_equal("cdd_dout paused position", pos, last_pos);
				expect_equal("cdd_dout track nibble", frame[35:32], track_at(exp_pos));
			end
			default:
				expect_equal("cdd_dout stopped position", pos, 24'h0);
		endcase
	endtask

	// Random command from the implemented set, one in eight corrupted
	task automatic pick_command(output logic [39:0] cmd, output bit valid);
		int unsigned kind;
		int unsigned toc_kind;
		logic [3:0] code;
		logic [3:0] sub;
		logic [23:0] payload;
		kind = $urandom_range(6);
		sub = 4'h0;
		payload = 24'h0;
		case (kind)
			0:
				code = CMD_NOP;
			1:
				code = CMD_STOP;
			2, 3:
			begin
				code = CMD_TOC;
				toc_kind = $urandom_range(3);
				sub = (toc_kind == 0) ? TOC_LENGTH :
					(toc_kind == 1) ? TOC_FIRSTLAST : TOC_START;
				// Track 4 is past the last track
				payload = {to_bcd($urandom_range(4, 1)), 16'h0};
			end
			4:
			begin
				code = CMD_PLAY;
				payload = {to_bcd($urandom_range(79)), to_bcd($urandom_range(59)),
					to_bcd($urandom_range(74))};
			end
			5:
				code = CMD_PAUSE;
			default:
				code = CMD_RESUME;
		endcase
		cmd = make_command(code, sub, payload);
		valid = ($urandom_range(7) != 0);
		if (!valid)
			cmd[39:36] = cmd[39:36] ^ 4'($urandom_range(15, 1));
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial
	begin : main_flow
		logic [39:0] frame;
		logic [39:0] cmd;
		bit valid;
		int i;
		void'($urandom(32'hb9e80c6b));
		checks = 0;
		errors = 0;
		timeouts = 0;
		timed_out = 1'b0;
		nRESET = 1'b0;
		hock = 1'b1;
		cdd_din = 4'h0;
		exp_status = STAT_STOPPED;
		exp_sub = 4'h0;
		exp_track = 8'h0;
		start_pos = 24'h0;
		last_pos = 24'h0;
		exp_pos = 24'h0;
		exp_run = 1'b0;

		repeat (8) @(negedge clk_sys);
		nRESET = 1'b1;
		@(negedge clk_sys);
		// Idle bus before the first interrupt
		expect_equal("cdck", cdck, 1'b1);
		expect_equal("cdd_nirq", cdd_nirq, 1'b1);

		for (i = 0; i < NUM_FRAMES; i++)
		begin
			if ((i == 4) || ($urandom_range(9) == 0))
			begin
				skip_irq();
				if (timed_out)
					break;
				advance_model();
			end
			read_status(frame);
			if (timed_out)
				break;
			advance_model();
			check_frame(frame, i == 0);
			pick_command(cmd, valid);
			write_command(cmd);
			if (timed_out)
				break;
			if (valid)
				apply_command(cmd);
		end

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if ((errors == 0) && (timeouts == 0))
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+sim
verilog/cdd_pkg.sv
verilog/cdd_msf_counter.sv
verilog/cdd_toc.sv
verilog/cdd_link.sv
verilog/cdd_controller.sv
verilog/cdd_top.sv
sim/tb_cdd.sv

//--- Bender.yml
package:
  name: cdd

sources:
  - files:
      - verilog/cdd_pkg.sv
      - verilog/cdd_msf_counter.sv
      - verilog/cdd_toc.sv
      - verilog/cdd_link.sv
      - verilog/cdd_controller.sv
      - verilog/cdd_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_cdd.sv
